// File: verilog/loader_pkg.sv
// Shared widths, file indices, CRT offsets and command word types for the file loader
package loader_pkg;

	// ============================================================
	// Widths and file indices
	// ============================================================
	localparam int ADDR_W = 25;                    // Memory address width
	localparam int DATA_W = 8;                     // Memory data width

	localparam logic [7:0] IDX_PRG = 8'd4;         // Host file index of a PRG image
	localparam logic [7:0] IDX_CRT = 8'd5;         // Host file index of a CRT image

	// ============================================================
	// CRT layout
	// ============================================================
	localparam logic [ADDR_W-1:0] CRT_BASE       = 25'h100000; // Cartridge data area
	localparam logic [ADDR_W-1:0] CRT_ID_OFS     = 25'h16;     // Id hi, id lo, EXROM, GAME
	localparam logic [ADDR_W-1:0] CRT_CHIP_START = 25'h40;     // First CHIP packet

	// ============================================================
	// Command word
	// ============================================================
	typedef struct packed {
		logic [22:0]       pad;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} mem_wr_t;

	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
	} bank_desc_t;

	// One 56-bit word, read by its kind
	typedef union packed {
		mem_wr_t    mem;
		bank_desc_t bank;
	} load_cmd_u;

	typedef enum logic {
		CMD_MEM  = 1'b0,   // Memory byte write
		CMD_BANK = 1'b1    // CHIP bank descriptor
	} cmd_kind_e;

endpackage

// File: verilog/load_cmd_if.sv
// Command and credit link between the stream decoder and the write queue
`timescale 1ns/1ps

interface load_cmd_if (
	input logic clk_sys
);

	logic                  cmd_valid;   // One cycle per command
	loader_pkg::cmd_kind_e cmd_kind;
	loader_pkg::load_cmd_u cmd_word;
	logic                  credit;      // One credit back per pop

	modport decode_mp (
		input  clk_sys,
		output cmd_valid,
		output cmd_kind,
		output cmd_word,
		input  credit
	);

	modport queue_mp (
		input  clk_sys,
		input  cmd_valid,
		input  cmd_kind,
		input  cmd_word,
		output credit
	);

endinterface

// File: verilog/load_stream_decode.sv
// Parses the host PRG and CRT byte streams and issues memory and bank commands under credit
`timescale 1ns/1ps

module load_stream_decode #(
	parameter int CMD_DEPTH = 4
) (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	input  logic                          dl_active_i,
	input  logic                          dl_wr_i,
	input  logic [7:0]                    dl_index_i,
	input  logic [loader_pkg::ADDR_W-1:0] dl_addr_i,
	input  logic [loader_pkg::DATA_W-1:0] dl_data_i,
	output logic                          dl_wait_o,
	output logic [15:0]                   cart_id_o,
	output logic [7:0]                    cart_exrom_o,
	output logic [7:0]                    cart_game_o,
	output logic                          cart_attached_o,
	output logic                          cart_clear_o,
	output logic [15:0]                   prg_start_o,
	output logic [15:0]                   prg_end_o,
	load_cmd_if.decode_mp                 cmd
);

	localparam int CNT_W   = $clog2(CMD_DEPTH + 1);
	localparam int PATCH_N = 12;   // BASIC pointer bytes

	logic [CNT_W-1:0]              credit_cnt;
	logic                          patch_busy;
	logic [3:0]                    patch_idx;
	logic [7:0]                    patch_ofs;
	logic                          active_d;
	logic [7:0]                    cur_idx;
	logic                          cart_attached;
	logic                          cart_clear;
	logic [3:0]                    hdr_cnt;     // Byte position inside a CHIP header
	logic [31:0]                   blk_len;     // Data bytes left in the current CHIP
	logic [loader_pkg::ADDR_W-1:0] load_addr;
	logic [15:0]                   prg_start;
	logic [15:0]                   prg_end;
	logic [15:0]                   cart_id;
	logic [7:0]                    cart_exrom;
	logic [7:0]                    cart_game;
	loader_pkg::bank_desc_t        chip_hdr;
	logic                          is_prg;
	logic                          is_crt;
	logic                          in_chip;
	logic                          issue;
	loader_pkg::cmd_kind_e         nxt_kind;
	loader_pkg::load_cmd_u         nxt_word;

	// Pointer bytes in address order
	function automatic logic [7:0] patch_addr(input logic [3:0] idx);
		case (idx)
			4'd0:    return 8'h2B;
			4'd1:    return 8'h2C;
			4'd2:    return 8'h2D;
			4'd3:    return 8'h2E;
			4'd4:    return 8'h2F;
			4'd5:    return 8'h30;
			4'd6:    return 8'h31;
			4'd7:    return 8'h32;
			4'd8:    return 8'hAC;
			4'd9:    return 8'hAD;
			4'd10:   return 8'hAE;
			default: return 8'hAF;
		endcase
	endfunction

	function automatic logic [7:0] patch_value(input logic [7:0] ofs, input logic [15:0] end_addr);
		case (ofs)
			8'h2B:                      return 8'h01;   // TXT start 0x0801
			8'h2C:                      return 8'h08;
			8'hAC, 8'hAD:               return 8'h00;   // SAVE start
			8'h2D, 8'h2F, 8'h31, 8'hAE: return end_addr[7:0];
			default:                    return end_addr[15:8];
		endcase
	endfunction

	assign is_prg    = (dl_index_i == loader_pkg::IDX_PRG);
	assign is_crt    = (dl_index_i == loader_pkg::IDX_CRT);
	assign in_chip   = (dl_addr_i >= loader_pkg::CRT_CHIP_START);
	assign patch_ofs = patch_addr(patch_idx);

	// ============================================================
	// Command selection
	// ============================================================
	always_comb begin
		issue    = 1'b0;
		nxt_kind = loader_pkg::CMD_MEM;
		nxt_word = '0;
		if (patch_busy) begin
			if (credit_cnt != '0) begin
				issue             = 1'b1;
				nxt_word.mem.addr = loader_pkg::ADDR_W'(patch_ofs);
				nxt_word.mem.data = patch_value(patch_ofs, prg_end);
			end
		end else if (dl_wr_i && is_prg && dl_addr_i > loader_pkg::ADDR_W'(1)) begin
			issue             = 1'b1;
			nxt_word.mem.addr = load_addr;
			nxt_word.mem.data = dl_data_i;
		end else if (dl_wr_i && is_crt && in_chip) begin
			if (hdr_cnt == 4'd15) begin   // Last header byte closes the descriptor
				issue                   = 1'b1;
				nxt_kind                = loader_pkg::CMD_BANK;
				nxt_word.bank           = chip_hdr;
				nxt_word.bank.size[7:0] = dl_data_i;
			end else if (hdr_cnt == 4'd0 && blk_len != '0) begin
				issue             = 1'b1;
				nxt_word.mem.addr = load_addr;
				nxt_word.mem.data = dl_data_i;
			end
		end
	end

	// ============================================================
	// Control state
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			cmd.cmd_valid <= 1'b0;
			credit_cnt    <= CNT_W'(CMD_DEPTH);
			patch_busy    <= 1'b0;
			patch_idx     <= '0;
			active_d      <= 1'b0;
			cur_idx       <= '0;
			cart_attached <= 1'b0;
			cart_clear    <= 1'b0;
			hdr_cnt       <= '0;
			blk_len       <= '0;
		end else begin
			cmd.cmd_valid <= issue;
			cart_clear    <= 1'b0;
			active_d      <= dl_active_i;
			if (dl_active_i) cur_idx <= dl_index_i;

			case ({issue, cmd.credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase

			// Download start and end
			if (dl_active_i && !active_d && is_crt) begin
				cart_attached <= 1'b0;
				cart_clear    <= 1'b1;
			end
			if (!dl_active_i && active_d) begin
				if (cur_idx == loader_pkg::IDX_PRG) begin
					patch_busy <= 1'b1;
					patch_idx  <= '0;
				end
				if (cur_idx == loader_pkg::IDX_CRT) cart_attached <= 1'b1;
			end

			if (patch_busy && issue) begin
				patch_idx <= patch_idx + 1'b1;
				if (patch_idx == 4'(PATCH_N - 1)) patch_busy <= 1'b0;   // Last pointer byte
			end

			if (dl_wr_i && is_crt) begin
				if (dl_addr_i == '0) begin
					hdr_cnt <= '0;
					blk_len <= '0;
				end else if (in_chip) begin
					if (hdr_cnt == 4'd0 && blk_len == '0) begin
						hdr_cnt <= 4'd1;   // New CHIP packet
					end else if (hdr_cnt != 4'd0) begin
						hdr_cnt <= hdr_cnt + 1'b1;   // Wraps to zero after byte 15
						case (hdr_cnt)
							4'd4:    blk_len[31:24] <= dl_data_i;
							4'd5:    blk_len[23:16] <= dl_data_i;
							4'd6:    blk_len[15:8]  <= dl_data_i;
							4'd7:    blk_len[7:0]   <= dl_data_i;
							4'd8:    blk_len        <= blk_len - 32'h10;   // Packet minus header
							default: blk_len        <= blk_len;
						endcase
					end else begin
						blk_len <= blk_len - 1'b1;
					end
				end
			end
		end
	end

	// ============================================================
	// Pointers, header fields and command payload
	// ============================================================
	always_ff @(posedge clk_sys) begin
		cmd.cmd_kind <= nxt_kind;
		cmd.cmd_word <= nxt_word;

		if (dl_wr_i && is_prg) begin
			if (dl_addr_i == '0) begin   // Load address low byte
				load_addr       <= loader_pkg::ADDR_W'(dl_data_i);
				prg_start[7:0]  <= dl_data_i;
				prg_end[7:0]    <= dl_data_i;
			end else if (dl_addr_i == loader_pkg::ADDR_W'(1)) begin
				load_addr[15:8] <= dl_data_i;
				prg_start[15:8] <= dl_data_i;
				prg_end[15:8]   <= dl_data_i;
			end else begin
				load_addr <= load_addr + 1'b1;
				prg_end   <= prg_end + 16'd1;
			end
		end

		if (dl_wr_i && is_crt) begin
			if (dl_addr_i == '0) load_addr <= loader_pkg::CRT_BASE;
			if (dl_addr_i == loader_pkg::CRT_ID_OFS) cart_id[15:8] <= dl_data_i;
			if (dl_addr_i == loader_pkg::CRT_ID_OFS + 1'b1) cart_id[7:0] <= dl_data_i;
			if (dl_addr_i == loader_pkg::CRT_ID_OFS + 2'd2) cart_exrom <= dl_data_i;
			if (dl_addr_i == loader_pkg::CRT_ID_OFS + 2'd3) cart_game <= dl_data_i;

			if (in_chip) begin
				if (hdr_cnt == 4'd0 && blk_len == '0) begin
					// Round the pointer up to the next 8 KB block
					if (load_addr[12:0] != '0)
						load_addr <= {load_addr[loader_pkg::ADDR_W-1:13] + 1'b1, 13'd0};
				end else if (hdr_cnt != 4'd0) begin
					case (hdr_cnt)
						4'd9:    chip_hdr.bank_type       <= dl_data_i;
						4'd10:   chip_hdr.bank_num[15:8]  <= dl_data_i;
						4'd11:   chip_hdr.bank_num[7:0]   <= dl_data_i;
						4'd12:   chip_hdr.load_addr[15:8] <= dl_data_i;
						4'd13:   chip_hdr.load_addr[7:0]  <= dl_data_i;
						4'd14:   chip_hdr.size[15:8]      <= dl_data_i;
						default: chip_hdr                 <= chip_hdr;
					endcase
				end else begin
					load_addr <= load_addr + 1'b1;
				end
			end
		end
	end

	assign dl_wait_o       = (credit_cnt == '0) | patch_busy;
	assign cart_id_o       = cart_id;
	assign cart_exrom_o    = cart_exrom;
	assign cart_game_o     = cart_game;
	assign cart_attached_o = cart_attached;
	assign cart_clear_o    = cart_clear;
	assign prg_start_o     = prg_start;
	assign prg_end_o       = prg_end;

endmodule

// File: verilog/load_write_queue.sv
// Command FIFO that spends memory slots on byte writes and forwards bank descriptors
`timescale 1ns/1ps

module load_write_queue #(
	parameter int CMD_DEPTH = 4
) (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	load_cmd_if.queue_mp                  cmd,
	input  logic                          mem_slot_i,
	output logic                          mem_we_o,
	output logic [loader_pkg::ADDR_W-1:0] mem_addr_o,
	output logic [loader_pkg::DATA_W-1:0] mem_data_o,
	output logic                          bank_wr_o,
	output loader_pkg::bank_desc_t        bank_desc_o
);

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);

	loader_pkg::cmd_kind_e kind_mem [CMD_DEPTH];
	loader_pkg::load_cmd_u word_mem [CMD_DEPTH];
	logic [PTR_W-1:0]      rd_ptr;
	logic [PTR_W-1:0]      wr_ptr;
	logic [CNT_W-1:0]      fill;
	loader_pkg::cmd_kind_e head_kind;
	loader_pkg::load_cmd_u head_word;
	logic                  push;
	logic                  pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(CMD_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign head_kind = kind_mem[rd_ptr];
	assign head_word = word_mem[rd_ptr];
	assign push      = cmd.cmd_valid;   // Credits guarantee room
	// Bank descriptors need no slot
	assign pop       = (fill != '0) && ((head_kind == loader_pkg::CMD_BANK) || mem_slot_i);

	always_ff @(posedge clk_sys) begin
		if (push) begin
			kind_mem[wr_ptr] <= cmd.cmd_kind;
			word_mem[wr_ptr] <= cmd.cmd_word;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			rd_ptr     <= '0;
			wr_ptr     <= '0;
			fill       <= '0;
			mem_we_o   <= 1'b0;
			bank_wr_o  <= 1'b0;
			cmd.credit <= 1'b0;
		end else begin
			if (push) wr_ptr <= ptr_inc(wr_ptr);
			if (pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase

			cmd.credit <= pop;   // Slot freed
			mem_we_o   <= pop && (head_kind == loader_pkg::CMD_MEM);
			bank_wr_o  <= pop && (head_kind == loader_pkg::CMD_BANK);
		end
	end

	// ============================================================
	// Head word, read as a write or as a descriptor
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (pop) begin
			if (head_kind == loader_pkg::CMD_MEM) begin
				mem_addr_o <= head_word.mem.addr;
				mem_data_o <= head_word.mem.data;
			end else begin
				bank_desc_o <= head_word.bank;
			end
		end
	end

endmodule

// File: verilog/crt_bank_table.sv
// Table of CHIP bank descriptors in arrival order, read back by slot number
`timescale 1ns/1ps

module crt_bank_table #(
	parameter int BANK_SLOTS = 8
) (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	input  logic                          clear_i,      // New CRT download
	input  logic                          bank_wr_i,
	input  loader_pkg::bank_desc_t        bank_desc_i,
	input  logic [$clog2(BANK_SLOTS)-1:0] bank_sel_i,
	output loader_pkg::bank_desc_t        bank_desc_o,
	output logic [7:0]                    bank_count_o
);

	localparam int SEL_W = $clog2(BANK_SLOTS);

	loader_pkg::bank_desc_t bank_mem [BANK_SLOTS];
	logic [7:0]             bank_count;
	logic                   store_ok;

	// Later descriptors are only counted
	assign store_ok = ({1'b0, bank_count} < 9'(BANK_SLOTS));

	always_ff @(posedge clk_sys) begin
		if (bank_wr_i && store_ok && !clear_i)
			bank_mem[bank_count[SEL_W-1:0]] <= bank_desc_i;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			bank_count <= '0;
		end else if (clear_i) begin
			bank_count <= '0;
		end else if (bank_wr_i && bank_count != 8'hFF) begin
			bank_count <= bank_count + 1'b1;   // Saturates
		end
	end

	assign bank_desc_o  = bank_mem[bank_sel_i];
	assign bank_count_o = bank_count;

endmodule

// File: verilog/cart_loader_top.sv
// Top level of the PRG and CRT file loader, host stream in and granted memory writes out
`timescale 1ns/1ps

module cart_loader_top #(
	parameter int CMD_DEPTH  = 4,
	parameter int BANK_SLOTS = 8
) (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	// Host stream
	input  logic                          dl_active_i,
	input  logic                          dl_wr_i,
	input  logic [7:0]                    dl_index_i,
	input  logic [loader_pkg::ADDR_W-1:0] dl_addr_i,
	input  logic [loader_pkg::DATA_W-1:0] dl_data_i,
	output logic                          dl_wait_o,
	// Memory side
	input  logic                          mem_slot_i,
	output logic                          mem_we_o,
	output logic [loader_pkg::ADDR_W-1:0] mem_addr_o,
	output logic [loader_pkg::DATA_W-1:0] mem_data_o,
	// Header fields
	output logic [15:0]                   cart_id_o,
	output logic [7:0]                    cart_exrom_o,
	output logic [7:0]                    cart_game_o,
	output logic                          cart_attached_o,
	output logic [15:0]                   prg_start_o,
	output logic [15:0]                   prg_end_o,
	// Bank table read
	input  logic [$clog2(BANK_SLOTS)-1:0] bank_sel_i,
	output loader_pkg::bank_desc_t        bank_desc_o,
	output logic [7:0]                    bank_count_o
);

	logic                   bank_wr;
	loader_pkg::bank_desc_t bank_desc;
	logic                   cart_clear;

	load_cmd_if u_cmd_if (.clk_sys(clk_sys));

	load_stream_decode #(.CMD_DEPTH(CMD_DEPTH)) u_decode (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_wr_i         (dl_wr_i),
		.dl_index_i      (dl_index_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_wait_o       (dl_wait_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.cart_attached_o (cart_attached_o),
		.cart_clear_o    (cart_clear),
		.prg_start_o     (prg_start_o),
		.prg_end_o       (prg_end_o),
		.cmd             (u_cmd_if.decode_mp)
	);

	load_write_queue #(.CMD_DEPTH(CMD_DEPTH)) u_queue (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.cmd         (u_cmd_if.queue_mp),
		.mem_slot_i  (mem_slot_i),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o),
		.bank_wr_o   (bank_wr),
		.bank_desc_o (bank_desc)
	);

	crt_bank_table #(.BANK_SLOTS(BANK_SLOTS)) u_bank_table (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.clear_i      (cart_clear),
		.bank_wr_i    (bank_wr),
		.bank_desc_i  (bank_desc),
		.bank_sel_i   (bank_sel_i),
		.bank_desc_o  (bank_desc_o),
		.bank_count_o (bank_count_o)
	);

endmodule

// File: testbench/loader_model.svh
// Reference model of the loader, included in the testbench module to build expected writes and banks
`ifndef LOADER_MODEL_SVH
`define LOADER_MODEL_SVH

logic [loader_pkg::ADDR_W-1:0] exp_addr_q [$];   // Expected writes in issue order
logic [7:0]                    exp_data_q [$];
loader_pkg::bank_desc_t        exp_bank_q [$];   // CHIP headers of the current CRT
logic [loader_pkg::ADDR_W-1:0] crt_ptr;

task automatic expect_write(input logic [loader_pkg::ADDR_W-1:0] addr, input logic [7:0] data);
	exp_addr_q.push_back(addr);
	exp_data_q.push_back(data);
endtask

// BASIC text at 0x0801, variable and array areas start at the program end
task automatic expect_prg_pointers(input logic [15:0] end_addr);
	expect_write(25'h2B, 8'h01);
	expect_write(25'h2C, 8'h08);
	expect_write(25'h2D, end_addr[7:0]);
	expect_write(25'h2E, end_addr[15:8]);
	expect_write(25'h2F, end_addr[7:0]);
	expect_write(25'h30, end_addr[15:8]);
	expect_write(25'h31, end_addr[7:0]);
	expect_write(25'h32, end_addr[15:8]);
	expect_write(25'hAC, 8'h00);   // Save start
	expect_write(25'hAD, 8'h00);
	expect_write(25'hAE, end_addr[7:0]);   // Load end
	expect_write(25'hAF, end_addr[15:8]);
endtask

task automatic crt_begin();
	crt_ptr = loader_pkg::CRT_BASE;
	exp_bank_q.delete();
endtask

task automatic crt_chip(input loader_pkg::bank_desc_t desc);
	crt_ptr = (crt_ptr + 25'h1FFF) & ~25'h1FFF;   // Next 8 KB boundary
	exp_bank_q.push_back(desc);
endtask

task automatic crt_data(input logic [7:0] data);
	expect_write(crt_ptr, data);
	crt_ptr = crt_ptr + 25'd1;
endtask

`endif

// File: testbench/tb_cart_loader.sv
// Testbench for the file loader that checks random PRG and CRT downloads against a reference model
`timescale 1ns/1ps

module tb_cart_loader;

	localparam int          CMD_DEPTH  = 4;
	localparam int          BANK_SLOTS = 8;
	localparam logic [31:0] SEED       = 32'h7f5f3e69;
	localparam int          HOST_LIMIT = 20000;    // Cycles the host may stall
	localparam int          IDLE_LIMIT = 400000;   // Cycles for the DUT to drain

	logic                            clk_sys;
	logic                            reset_n;
	logic                            dl_active_i;
	logic                            dl_wr_i;
	logic [7:0]                      dl_index_i;
	logic [loader_pkg::ADDR_W-1:0]   dl_addr_i;
	logic [loader_pkg::DATA_W-1:0]   dl_data_i;
	logic                            dl_wait_o;
	logic                            mem_slot_i;
	logic                            mem_we_o;
	logic [loader_pkg::ADDR_W-1:0]   mem_addr_o;
	logic [loader_pkg::DATA_W-1:0]   mem_data_o;
	logic [15:0]                     cart_id_o;
	logic [7:0]                      cart_exrom_o;
	logic [7:0]                      cart_game_o;
	logic                            cart_attached_o;
	logic [15:0]                     prg_start_o;
	logic [15:0]                     prg_end_o;
	logic [$clog2(BANK_SLOTS)-1:0]   bank_sel_i;
	loader_pkg::bank_desc_t          bank_desc_o;
	logic [7:0]                      bank_count_o;

	logic [31:0]                   host_lfsr;
	logic [31:0]                   slot_lfsr;
	logic                          slot_sparse;   // Long gaps between slots
	logic                          slot_q;
	logic [loader_pkg::ADDR_W-1:0] exp_addr;
	logic [7:0]                    exp_data;
	int                            errors;
	int                            writes_checked;
	int                            banks_checked;

	`include "loader_model.svh"

	cart_loader_top #(.CMD_DEPTH(CMD_DEPTH), .BANK_SLOTS(BANK_SLOTS)) u_cart_loader_top (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_wr_i         (dl_wr_i),
		.dl_index_i      (dl_index_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_wait_o       (dl_wait_o),
		.mem_slot_i      (mem_slot_i),
		.mem_we_o        (mem_we_o),
		.mem_addr_o      (mem_addr_o),
		.mem_data_o      (mem_data_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.cart_attached_o (cart_attached_o),
		.prg_start_o     (prg_start_o),
		.prg_end_o       (prg_end_o),
		.bank_sel_i      (bank_sel_i),
		.bank_desc_o     (bank_desc_o),
		.bank_count_o    (bank_count_o)
	);

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] draw_bits(input int n, input logic from_slot);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			if (from_slot) begin
				r         = {r[30:0], slot_lfsr[31]};
				slot_lfsr = lfsr_next(slot_lfsr);
			end else begin
				r         = {r[30:0], host_lfsr[31]};
				host_lfsr = lfsr_next(host_lfsr);
			end
		end
		return r;
	endfunction

	task automatic log_error(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic log_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic report_counts();
		$display("Writes checked: %0d, banks checked: %0d, errors: %0d",
			writes_checked, banks_checked, errors);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		report_counts();
		$display("Simulation failed");
		$finish;
	endtask

	// ============================================================
	// Clock, memory slots and write monitor
	// ============================================================
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		mem_slot_i = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (slot_sparse)
				mem_slot_i = (draw_bits(6, 1'b1) == 32'd0);
			else
				mem_slot_i = (draw_bits(2, 1'b1) != 32'd0);
		end
	end

	always @(posedge clk_sys) begin
		slot_q <= mem_slot_i;   // Slot seen by the queue at this edge
	end

	always @(negedge clk_sys) begin
		if (reset_n && mem_we_o) begin
			assert (slot_q)
			else log_failure($sformatf("Memory write at %0t ns came without a slot", $time));
			assert (exp_addr_q.size() != 0)
			else log_failure($sformatf("Unexpected memory write to %h at %0t ns", mem_addr_o, $time));
			if (exp_addr_q.size() != 0) begin
				exp_addr = exp_addr_q.pop_front();
				exp_data = exp_data_q.pop_front();
				writes_checked++;
				assert (mem_addr_o == exp_addr && mem_data_o == exp_data)
				else log_error($sformatf("write %h=%h, expected %h=%h",
					mem_addr_o, mem_data_o, exp_addr, exp_data));
			end
		end
	end

	// ============================================================
	// Host side
	// ============================================================
	task automatic send_byte(input logic [loader_pkg::ADDR_W-1:0] addr, input logic [7:0] data);
		int gap;
		int waited;
		gap    = int'(draw_bits(2, 1'b0));
		waited = 0;
		repeat (gap) @(negedge clk_sys);
		while (dl_wait_o) begin
			waited++;
			if (waited > HOST_LIMIT)
				abort_run("Timeout: dl_wait_o held the host stream too long");
			@(negedge clk_sys);
		end
		dl_wr_i   = 1'b1;
		dl_addr_i = addr;
		dl_data_i = data;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
	endtask

	task automatic wait_idle(input string what);
		int waited;
		waited = 0;
		while (exp_addr_q.size() != 0 || dl_wait_o || mem_we_o) begin
			waited++;
			if (waited > IDLE_LIMIT)
				abort_run({"Timeout: the ", what, " writes never drained"});
			@(negedge clk_sys);
		end
	endtask

	task automatic run_prg();
		logic [15:0] start;
		logic [7:0]  b;
		int          len;
		int          i;
		start       = 16'h0800 + 16'(draw_bits(12, 1'b0));
		len         = 8 + int'(draw_bits(6, 1'b0));
		dl_index_i  = loader_pkg::IDX_PRG;
		dl_active_i = 1'b1;
		@(negedge clk_sys);
		send_byte(25'd0, start[7:0]);
		send_byte(25'd1, start[15:8]);
		for (i = 0; i < len; i++) begin
			b = 8'(draw_bits(8, 1'b0));
			expect_write(25'(start) + 25'(i), b);
			send_byte(25'(i + 2), b);
		end
		dl_active_i = 1'b0;
		expect_prg_pointers(start + 16'(len));
		wait_idle("PRG");
		assert (prg_start_o == start && prg_end_o == start + 16'(len))
		else log_error($sformatf("PRG range %h-%h, expected %h-%h",
			prg_start_o, prg_end_o, start, start + 16'(len)));
	endtask

	task automatic check_banks();
		int                     s;
		loader_pkg::bank_desc_t exp;
		assert (bank_count_o == 8'(exp_bank_q.size()))
		else log_error($sformatf("bank count %0d, expected %0d", bank_count_o, exp_bank_q.size()));
		for (s = 0; s < exp_bank_q.size(); s++) begin
			bank_sel_i = s[$clog2(BANK_SLOTS)-1:0];
			@(negedge clk_sys);
			exp = exp_bank_q[s];
			banks_checked++;
			assert (bank_desc_o == exp)
			else log_error($sformatf("bank %0d reads %h, expected %h", s, bank_desc_o, exp));
		end
	endtask

	task automatic run_crt(input int chips);
		logic [loader_pkg::ADDR_W-1:0] addr;
		logic [7:0]                    b;
		logic [7:0]                    hdr_byte [16];
		logic [15:0]                   id;
		logic [7:0]                    exrom;
		logic [7:0]                    game;
		logic [15:0]                   pkt_len;
		loader_pkg::bank_desc_t        desc;
		int                            size;
		int                            c;
		int                            i;
		dl_index_i  = loader_pkg::IDX_CRT;
		dl_active_i = 1'b1;
		repeat (2) @(negedge clk_sys);   // Clear pulse and then the cleared bank count
		assert (!cart_attached_o && bank_count_o == 8'd0)
		else log_error($sformatf("new CRT left attached %0b and bank count %0d, expected 0 and 0",
			cart_attached_o, bank_count_o));
		crt_begin();
		for (i = 0; i < 64; i++) begin
			b = 8'(draw_bits(8, 1'b0));
			case (i)
				'h16:    id[15:8] = b;
				'h17:    id[7:0]  = b;
				'h18:    exrom    = b;
				'h19:    game     = b;
				default: ;
			endcase
			send_byte(25'(i), b);
		end
		addr = loader_pkg::CRT_CHIP_START;
		for (c = 0; c < chips; c++) begin
			size           = 1 + int'(draw_bits(6, 1'b0));
			pkt_len        = 16'(16 + size);   // CHIP header plus data
			desc.bank_type = 8'(draw_bits(8, 1'b0));
			desc.bank_num  = 16'(draw_bits(16, 1'b0));
			desc.load_addr = (draw_bits(1, 1'b0) != 32'd0) ? 16'hA000 : 16'h8000;
			desc.size      = 16'(size);
			hdr_byte       = '{8'h43, 8'h48, 8'h49, 8'h50, 8'h00, 8'h00,
				pkt_len[15:8], pkt_len[7:0], 8'h00, desc.bank_type,
				desc.bank_num[15:8], desc.bank_num[7:0], desc.load_addr[15:8],
				desc.load_addr[7:0], desc.size[15:8], desc.size[7:0]};
			crt_chip(desc);
			for (i = 0; i < 16; i++) begin
				send_byte(addr, hdr_byte[i]);
				addr = addr + 25'd1;
			end
			for (i = 0; i < size; i++) begin
				b = 8'(draw_bits(8, 1'b0));
				crt_data(b);
				send_byte(addr, b);
				addr = addr + 25'd1;
			end
		end
		dl_active_i = 1'b0;
		wait_idle("CRT");
		assert (cart_attached_o)
		else log_error("cart_attached_o is 0 after the CRT download, expected 1");
		assert (cart_id_o == id && cart_exrom_o == exrom && cart_game_o == game)
		else log_error($sformatf("CRT header %h/%h/%h, expected %h/%h/%h",
			cart_id_o, cart_exrom_o, cart_game_o, id, exrom, game));
		check_banks();
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		reset_n        = 1'b0;
		dl_active_i    = 1'b0;
		dl_wr_i        = 1'b0;
		dl_index_i     = '0;
		dl_addr_i      = '0;
		dl_data_i      = '0;
		bank_sel_i     = '0;
		slot_sparse    <= 1'b0;
		errors         = 0;
		writes_checked = 0;
		banks_checked  = 0;
		host_lfsr      = SEED;
		slot_lfsr      = draw_bits(32, 1'b0);   // Slot stream seeded from the host stream

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_n = 1'b1;
		assert (!mem_we_o && !dl_wait_o && bank_count_o == 8'd0 && !cart_attached_o)
		else log_error($sformatf("after reset we %0b wait %0b banks %0d attached %0b, expected 0",
			mem_we_o, dl_wait_o, bank_count_o, cart_attached_o));

		run_prg();
		slot_sparse <= 1'b1;
		run_prg();
		slot_sparse <= 1'b0;
		run_crt(4);
		slot_sparse <= 1'b1;
		run_crt(3);   // Second CRT clears the first
		slot_sparse <= 1'b0;

		repeat (32) @(negedge clk_sys);   // Stray writes would show here
		report_counts();
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+testbench
verilog/loader_pkg.sv
verilog/load_cmd_if.sv
verilog/load_stream_decode.sv
verilog/load_write_queue.sv
verilog/crt_bank_table.sv
verilog/cart_loader_top.sv
testbench/tb_cart_loader.sv

// File: run.sh
#!/bin/sh
# Compiles the loader testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_cart_loader -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_cart_loader)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1
